/* build.f */
tcdm_pkg.sv
tcdm_sram.sv
amo_alu.sv
amo_unit.sv
lrsc_monitor.sv
bank_arbiter.sv
resp_buffer.sv
tcdm_bank_top.sv
tb_tcdm_bank.sv

/* run.sh */
#!/usr/bin/env bash
# builds the tcdm bank testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       --top-module tb_tcdm_bank -f build.f -o tb_tcdm_bank \
  && ./obj_dir/tb_tcdm_bank > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* tb_tcdm_bank.sv */
// ----------------------------------------------------------
// tcdm bank testbench: stimulus, shadow memory, reservation
// model and in-order response checks
// ----------------------------------------------------------
`default_nettype none

module tb_tcdm_bank;
  timeunit 1ns;
  timeprecision 1ps;

  // longest wait for an accept or for the response queue to drain
  localparam int WaitLimit = 200;

  logic                             clk_i = 1'b0;
  logic                             rst_ni;
  logic                             in_valid_i;
  logic                             in_ready_o;
  logic [tcdm_pkg::AddrWidth-1:0]   in_addr_i;
  tcdm_pkg::amo_op_e                in_amo_i;
  logic                             in_write_i;
  logic [tcdm_pkg::DataWidth-1:0]   in_wdata_i;
  logic [tcdm_pkg::BeWidth-1:0]     in_be_i;
  logic [tcdm_pkg::CoreIdWidth-1:0] in_core_id_i;
  logic                             in_valid_o;
  logic                             in_ready_i;
  logic [tcdm_pkg::DataWidth-1:0]   in_rdata_o;
  logic [tcdm_pkg::CoreIdWidth-1:0] in_core_id_o;

  // shadow memory and reservation model
  logic [31:0] shadow [tcdm_pkg::NumWords];
  logic        resv_valid;
  logic [7:0]  resv_addr;
  logic [3:0]  resv_id;
  // expected responses in order of acceptance
  logic [31:0] exp_data_q [$];
  logic [3:0]  exp_id_q [$];

  logic [31:0] seed;
  logic        bp_on;
  int          stall_left;
  int          errors;
  int          err_mark;
  int          checks;

  always #50 clk_i = ~clk_i;

  tcdm_bank_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_addr_i    (in_addr_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .in_core_id_i (in_core_id_i),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_rdata_o   (in_rdata_o),
    .in_core_id_o (in_core_id_o)
  );

  // lcg, same constants as the classic numerical recipes one
  function automatic logic [31:0] rnd();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // write-back value of an atomic, straight from the opcode rules
  function automatic logic [31:0] amo_result(tcdm_pkg::amo_op_e op, logic [31:0] old,
                                             logic [31:0] opd);
    case (op)
      tcdm_pkg::AmoSwap: return opd;
      tcdm_pkg::AmoAdd:  return old + opd;
      tcdm_pkg::AmoAnd:  return old & opd;
      tcdm_pkg::AmoOr:   return old | opd;
      tcdm_pkg::AmoXor:  return old ^ opd;
      tcdm_pkg::AmoMax:  return ($signed(old) > $signed(opd)) ? old : opd;
      tcdm_pkg::AmoMaxu: return (old > opd) ? old : opd;
      tcdm_pkg::AmoMin:  return ($signed(old) < $signed(opd)) ? old : opd;
      tcdm_pkg::AmoMinu: return (old < opd) ? old : opd;
      default:           return old;
    endcase
  endfunction

  // ----------------------------------------------------------
  // model update at accept, response check at take
  // ----------------------------------------------------------
  task automatic model_accept();
    logic [31:0] old;
    logic        hit;
    logic        sc_passed;
    old = shadow[in_addr_i];
    hit = resv_valid && (resv_addr == in_addr_i);
    if (in_write_i) begin
      for (int b = 0; b < 4; b++) begin
        if (in_be_i[b]) shadow[in_addr_i][b*8 +: 8] = in_wdata_i[b*8 +: 8];
      end
      if (hit) resv_valid = 1'b0;
    end else if (in_amo_i == tcdm_pkg::AmoLr) begin
      exp_data_q.push_back(old);
      resv_valid = 1'b1;
      resv_addr  = in_addr_i;
      resv_id    = in_core_id_i;
    end else if (in_amo_i == tcdm_pkg::AmoSc) begin
      sc_passed = hit && (resv_id == in_core_id_i);
      exp_data_q.push_back(sc_passed ? 32'd0 : 32'd1);
      if (sc_passed) begin
        for (int b = 0; b < 4; b++) begin
          if (in_be_i[b]) shadow[in_addr_i][b*8 +: 8] = in_wdata_i[b*8 +: 8];
        end
        resv_valid = 1'b0;
      end
    end else if (in_amo_i == tcdm_pkg::AmoNone) begin
      exp_data_q.push_back(old);
    end else begin
      exp_data_q.push_back(old);
      shadow[in_addr_i] = amo_result(in_amo_i, old, in_wdata_i);
      if (hit) resv_valid = 1'b0;
    end
    // plain stores have no response, so no id either
    if (!in_write_i) exp_id_q.push_back(in_core_id_i);
  endtask

  task automatic check_response();
    logic [31:0] exp_d;
    logic [3:0]  exp_id;
    if (exp_data_q.size() == 0) begin
      $display("response at %0t arrived with no request outstanding", $time);
      errors++;
    end else begin
      exp_d  = exp_data_q.pop_front();
      exp_id = exp_id_q.pop_front();
      checks++;
      assert (in_rdata_o == exp_d) else begin
        $display("Error at %0t: in_rdata_o = %h, expected %h", $time, in_rdata_o, exp_d);
        errors++;
      end
      assert (in_core_id_o == exp_id) else begin
        $display("Error at %0t: in_core_id_o = %h, expected %h", $time, in_core_id_o, exp_id);
        errors++;
      end
    end
  endtask

  // mid-cycle sampling, inputs and outputs are settled here
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // a held response must block new requests
      assert (!(in_valid_o && !in_ready_i && in_ready_o)) else begin
        $display("Error at %0t: in_ready_o = 1, expected 0 while a response is held", $time);
        errors++;
      end
      if (in_valid_o && in_ready_i) check_response();
      if (in_valid_i && in_ready_o) model_accept();
    end
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  // one clock, with random stretches of response back-pressure
  task automatic step();
    @(posedge clk_i);
    if (!bp_on) begin
      in_ready_i <= 1'b1;
    end else if (stall_left > 0) begin
      in_ready_i <= 1'b0;
      stall_left--;
    end else if (rnd() % 3 == 0) begin
      in_ready_i <= 1'b0;
      stall_left = rnd() % 6;
    end else begin
      in_ready_i <= 1'b1;
    end
  endtask

  task automatic send(tcdm_pkg::amo_op_e op, logic wr, logic [7:0] addr, logic [31:0] data,
                      logic [3:0] be, logic [3:0] id);
    int   waited;
    logic accepted;
    in_valid_i   <= 1'b1;
    in_amo_i     <= op;
    in_write_i   <= wr;
    in_addr_i    <= addr;
    in_wdata_i   <= data;
    in_be_i      <= be;
    in_core_id_i <= id;
    waited = 0;
    do begin
      @(negedge clk_i);
      accepted = in_ready_o;
      step();
      waited++;
    end while (!accepted && waited < WaitLimit);
    in_valid_i <= 1'b0;
    if (!accepted) begin
      $display("timeout: request to address %h was never accepted", addr);
      errors++;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < WaitLimit) begin
      step();
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      $display("timeout: %0d responses never arrived", exp_data_q.size());
      errors++;
      exp_data_q.delete();
      exp_id_q.delete();
    end
  endtask

  task automatic end_test(string name);
    drain();
    if (errors == err_mark) $display("test %s: ok", name);
    else $display("test %s: failed, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  task automatic test_reset();
    @(negedge clk_i);
    assert (in_valid_o == 1'b0) else begin
      $display("Error at %0t: in_valid_o = %b, expected 0", $time, in_valid_o);
      errors++;
    end
    assert (in_ready_o == 1'b1) else begin
      $display("Error at %0t: in_ready_o = %b, expected 1", $time, in_ready_o);
      errors++;
    end
    step();
    end_test("after reset");
  endtask

  task automatic test_store_load();
    logic [31:0] r;
    for (int i = 0; i < 12; i++) begin
      r = rnd();
      // full word first so the later load reads nothing undefined
      send(tcdm_pkg::AmoNone, 1'b1, r[7:0], rnd(), 4'hF, r[11:8]);
      send(tcdm_pkg::AmoNone, 1'b1, r[7:0], rnd(), r[15:12], r[19:16]);
      send(tcdm_pkg::AmoNone, 1'b0, r[7:0], '0, 4'hF, r[23:20]);
    end
    end_test("stores and loads");
  endtask

  task automatic test_atomics();
    logic [31:0]       olds [6];
    logic [31:0]       opds [6];
    tcdm_pkg::amo_op_e op;
    // signed and unsigned extremes
    olds[0] = 32'h7FFF_FFFF;
    opds[0] = 32'h8000_0000;
    olds[1] = 32'h8000_0000;
    opds[1] = 32'h7FFF_FFFF;
    olds[2] = 32'hFFFF_FFFF;
    opds[2] = 32'h0000_0001;
    olds[3] = 32'h0000_0001;
    opds[3] = 32'hFFFF_FFFF;
    for (int k = 1; k <= 9; k++) begin
      op = tcdm_pkg::amo_op_e'(k[3:0]);
      olds[4] = rnd();
      opds[4] = rnd();
      olds[5] = rnd();
      opds[5] = rnd();
      for (int j = 0; j < 6; j++) begin
        send(tcdm_pkg::AmoNone, 1'b1, 8'h80 + j[7:0], olds[j], 4'hF, 4'h0);
        send(op, 1'b0, 8'h80 + j[7:0], opds[j], 4'hF, k[3:0]);
        send(tcdm_pkg::AmoNone, 1'b0, 8'h80 + j[7:0], '0, 4'hF, 4'h2);
      end
    end
    end_test("atomics");
  endtask

  task automatic test_lrsc();
    send(tcdm_pkg::AmoNone, 1'b1, 8'h20, rnd(), 4'hF, 4'h1);
    send(tcdm_pkg::AmoLr, 1'b0, 8'h20, '0, 4'hF, 4'h1);
    send(tcdm_pkg::AmoSc, 1'b0, 8'h20, 32'hCAFE_0001, 4'hF, 4'h1);
    send(tcdm_pkg::AmoNone, 1'b0, 8'h20, '0, 4'hF, 4'h1);
    // reservation is gone after a passing sc
    send(tcdm_pkg::AmoSc, 1'b0, 8'h20, 32'hDEAD_0002, 4'hF, 4'h1);
    send(tcdm_pkg::AmoLr, 1'b0, 8'h20, '0, 4'hF, 4'h1);
    send(tcdm_pkg::AmoSc, 1'b0, 8'h20, 32'hBEEF_0003, 4'hF, 4'h2);
    send(tcdm_pkg::AmoNone, 1'b0, 8'h20, '0, 4'hF, 4'h2);
    end_test("lr/sc");
  endtask

  task automatic test_resv_clear();
    send(tcdm_pkg::AmoNone, 1'b1, 8'h30, rnd(), 4'hF, 4'h3);
    send(tcdm_pkg::AmoLr, 1'b0, 8'h30, '0, 4'hF, 4'h3);
    send(tcdm_pkg::AmoNone, 1'b1, 8'h30, rnd(), 4'h3, 4'h5);
    send(tcdm_pkg::AmoSc, 1'b0, 8'h30, rnd(), 4'hF, 4'h3);
    // atomic write-back from another core breaks it too
    send(tcdm_pkg::AmoLr, 1'b0, 8'h30, '0, 4'hF, 4'h3);
    send(tcdm_pkg::AmoAdd, 1'b0, 8'h30, 32'd1, 4'hF, 4'h6);
    send(tcdm_pkg::AmoSc, 1'b0, 8'h30, rnd(), 4'hF, 4'h3);
    send(tcdm_pkg::AmoNone, 1'b0, 8'h30, '0, 4'hF, 4'h3);
    end_test("reservation clear");
  endtask

  task automatic test_backpressure();
    logic [31:0]       r;
    logic [7:0]        a;
    int unsigned       n;
    tcdm_pkg::amo_op_e op;
    bp_on = 1'b1;
    for (int i = 0; i < 16; i++) begin
      send(tcdm_pkg::AmoNone, 1'b1, 8'h40 + i[7:0], rnd(), 4'hF, 4'h0);
    end
    for (int i = 0; i < 150; i++) begin
      r = rnd();
      a = 8'h40 + {4'h0, r[3:0]};
      n = r[31:20] % 9;
      op = tcdm_pkg::amo_op_e'(n[3:0] + 4'd1);
      case (r[18:16])
        3'd0, 3'd1: send(tcdm_pkg::AmoNone, 1'b1, a, rnd(), r[7:4], {3'b0, r[19]});
        3'd2, 3'd3: send(tcdm_pkg::AmoNone, 1'b0, a, '0, 4'hF, {3'b0, r[19]});
        3'd4, 3'd5: send(op, 1'b0, a, rnd(), 4'hF, {3'b0, r[19]});
        3'd6:       send(tcdm_pkg::AmoLr, 1'b0, a, '0, 4'hF, {3'b0, r[19]});
        default:    send(tcdm_pkg::AmoSc, 1'b0, a, rnd(), 4'hF, {3'b0, r[19]});
      endcase
    end
    end_test("back-pressure mix");
    bp_on = 1'b0;
  endtask

  initial begin
    rst_ni       <= 1'b0;
    in_valid_i   <= 1'b0;
    in_addr_i    <= '0;
    in_amo_i     <= tcdm_pkg::AmoNone;
    in_write_i   <= 1'b0;
    in_wdata_i   <= '0;
    in_be_i      <= '0;
    in_core_id_i <= '0;
    in_ready_i   <= 1'b1;
    seed       = 32'd8;
    bp_on      = 1'b0;
    stall_left = 0;
    errors     = 0;
    err_mark   = 0;
    checks     = 0;
    resv_valid = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_reset();
    test_store_load();
    test_atomics();
    test_lrsc();
    test_resv_clear();
    test_backpressure();
    $display("%0d responses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tcdm_bank_top.sv */
// ----------------------------------------------------------
// tcdm bank top: sram, atomics, lr/sc, arbiter, response reg
// ----------------------------------------------------------
`default_nettype none

module tcdm_bank_top (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  // core request
  input  wire logic                             in_valid_i,
  output logic                                  in_ready_o,
  input  wire logic [tcdm_pkg::AddrWidth-1:0]   in_addr_i,
  input  wire tcdm_pkg::amo_op_e                in_amo_i,
  input  wire logic                             in_write_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0]   in_wdata_i,
  input  wire logic [tcdm_pkg::BeWidth-1:0]     in_be_i,
  input  wire logic [tcdm_pkg::CoreIdWidth-1:0] in_core_id_i,
  // core response
  output logic                                  in_valid_o,
  input  wire logic                             in_ready_i,
  output logic      [tcdm_pkg::DataWidth-1:0]   in_rdata_o,
  output logic      [tcdm_pkg::CoreIdWidth-1:0] in_core_id_o
);

  // sram port
  logic                           mem_req;
  logic                           mem_we;
  logic [tcdm_pkg::AddrWidth-1:0] mem_addr;
  logic [tcdm_pkg::DataWidth-1:0] mem_wdata;
  logic [tcdm_pkg::BeWidth-1:0]   mem_be;
  logic [tcdm_pkg::DataWidth-1:0] mem_rdata;
  // atomic write-back
  logic                           amo_busy;
  logic [tcdm_pkg::AddrWidth-1:0] amo_wb_addr;
  logic [tcdm_pkg::DataWidth-1:0] amo_wb_data;
  // handshake and sc status
  logic                           req_accept;
  logic                           resp_push;
  logic                           resp_stall;
  logic                           sc_pass;
  logic                           sc_resp;
  logic                           sc_fail;

  tcdm_sram i_sram (
    .clk_i       (clk_i),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_be_i    (mem_be),
    .mem_rdata_o (mem_rdata)
  );

  amo_unit i_amo_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_accept_i  (req_accept),
    .in_amo_i      (in_amo_i),
    .in_addr_i     (in_addr_i),
    .in_wdata_i    (in_wdata_i),
    .mem_rdata_i   (mem_rdata),
    .amo_busy_o    (amo_busy),
    .amo_wb_addr_o (amo_wb_addr),
    .amo_wb_data_o (amo_wb_data)
  );

  lrsc_monitor i_lrsc_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_accept_i  (req_accept),
    .in_amo_i      (in_amo_i),
    .in_write_i    (in_write_i),
    .in_addr_i     (in_addr_i),
    .in_core_id_i  (in_core_id_i),
    .amo_busy_i    (amo_busy),
    .amo_wb_addr_i (amo_wb_addr),
    .sc_pass_o     (sc_pass),
    .sc_resp_o     (sc_resp),
    .sc_fail_o     (sc_fail)
  );

  bank_arbiter i_bank_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid_i),
    .in_write_i    (in_write_i),
    .in_amo_i      (in_amo_i),
    .in_addr_i     (in_addr_i),
    .in_wdata_i    (in_wdata_i),
    .in_be_i       (in_be_i),
    .amo_busy_i    (amo_busy),
    .amo_wb_addr_i (amo_wb_addr),
    .amo_wb_data_i (amo_wb_data),
    .sc_pass_i     (sc_pass),
    .resp_stall_i  (resp_stall),
    .in_ready_o    (in_ready_o),
    .req_accept_o  (req_accept),
    .resp_push_o   (resp_push),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_be_o      (mem_be)
  );

  resp_buffer i_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .resp_push_i  (resp_push),
    .in_core_id_i (in_core_id_i),
    .mem_rdata_i  (mem_rdata),
    .sc_resp_i    (sc_resp),
    .sc_fail_i    (sc_fail),
    .in_ready_i   (in_ready_i),
    .in_valid_o   (in_valid_o),
    .in_rdata_o   (in_rdata_o),
    .in_core_id_o (in_core_id_o),
    .resp_stall_o (resp_stall)
  );

endmodule

`default_nettype wire

/* resp_buffer.sv */
// ----------------------------------------------------------
// one-entry fall-through response register with core id tag
// ----------------------------------------------------------
`default_nettype none

module resp_buffer (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             resp_push_i,
  input  wire logic [tcdm_pkg::CoreIdWidth-1:0] in_core_id_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0]   mem_rdata_i,
  input  wire logic                             sc_resp_i,
  input  wire logic                             sc_fail_i,
  input  wire logic                             in_ready_i,
  output logic                                  in_valid_o,
  output logic      [tcdm_pkg::DataWidth-1:0]   in_rdata_o,
  output logic      [tcdm_pkg::CoreIdWidth-1:0] in_core_id_o,
  output logic                                  resp_stall_o
);

  logic [tcdm_pkg::CoreIdWidth-1:0] acc_id_q;
  logic [tcdm_pkg::CoreIdWidth-1:0] held_id_q;
  logic [tcdm_pkg::DataWidth-1:0]   held_data_q;
  logic [tcdm_pkg::DataWidth-1:0]   resp_data;
  logic                             full_q;

  // push comes one cycle after accept, so last cycle's id is the tag
  always_ff @(posedge clk_i) begin
    acc_id_q <= in_core_id_i;
  end

  // sc answers 0 on success, 1 on failure
  assign resp_data = sc_resp_i ? {{(tcdm_pkg::DataWidth-1){1'b0}}, sc_fail_i} : mem_rdata_i;

  assign in_valid_o   = full_q || resp_push_i;
  assign in_rdata_o   = full_q ? held_data_q : resp_data;
  assign in_core_id_o = full_q ? held_id_q : acc_id_q;
  assign resp_stall_o = in_valid_o && !in_ready_i;

  // ----------------------------------------------------------
  // entry fill and drain
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !in_ready_i;
    end else begin
      full_q <= resp_push_i && !in_ready_i;
    end
  end

  // capture only when the fall-through response is refused
  always_ff @(posedge clk_i) begin
    if (!full_q && resp_push_i && !in_ready_i) begin
      held_data_q <= resp_data;
      held_id_q   <= acc_id_q;
    end
  end

  // arbiter back-pressure keeps a second response from piling up
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_push_i |-> !(full_q && !in_ready_i)
  );

endmodule

`default_nettype wire

/* bank_arbiter.sv */
// ----------------------------------------------------------
// sram port arbitration between core path and atomic write-back
// ----------------------------------------------------------
`default_nettype none

module bank_arbiter (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           in_valid_i,
  input  wire logic                           in_write_i,
  input  wire tcdm_pkg::amo_op_e              in_amo_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0] in_addr_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] in_wdata_i,
  input  wire logic [tcdm_pkg::BeWidth-1:0]   in_be_i,
  input  wire logic                           amo_busy_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0] amo_wb_addr_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] amo_wb_data_i,
  input  wire logic                           sc_pass_i,
  input  wire logic                           resp_stall_i,
  output logic                                in_ready_o,
  output logic                                req_accept_o,
  output logic                                resp_push_o,
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic      [tcdm_pkg::AddrWidth-1:0] mem_addr_o,
  output logic      [tcdm_pkg::DataWidth-1:0] mem_wdata_o,
  output logic      [tcdm_pkg::BeWidth-1:0]   mem_be_o
);

  logic core_we;

  // stall while the write-back owns the port or a response is stuck
  assign in_ready_o   = !amo_busy_i && !resp_stall_i;
  assign req_accept_o = in_valid_i && in_ready_o;

  // plain store, or an sc that holds the reservation
  assign core_we = in_write_i || ((in_amo_i == tcdm_pkg::AmoSc) && sc_pass_i);

  // ----------------------------------------------------------
  // port mux, write-back has priority
  // ----------------------------------------------------------
  always_comb begin
    if (amo_busy_i) begin
      mem_req_o   = 1'b1;
      mem_we_o    = 1'b1;
      mem_addr_o  = amo_wb_addr_i;
      mem_wdata_o = amo_wb_data_i;
      mem_be_o    = '1;
    end else begin
      mem_req_o   = req_accept_o;
      mem_we_o    = core_we;
      mem_addr_o  = in_addr_i;
      mem_wdata_o = in_wdata_i;
      mem_be_o    = in_be_i;
    end
  end

  // everything except a plain store answers, when read data is ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_push_o <= 1'b0;
    end else begin
      resp_push_o <= req_accept_o && !in_write_i;
    end
  end

  // write-back only ever directly follows the accept of its own atomic
  a_port_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    amo_busy_i |-> ($past(req_accept_o) && (amo_wb_addr_i == $past(in_addr_i)))
  );

endmodule

`default_nettype wire

/* lrsc_monitor.sv */
// ----------------------------------------------------------
// bank reservation for lr/sc and store-conditional outcome
// ----------------------------------------------------------
`default_nettype none

module lrsc_monitor (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             req_accept_i,
  input  wire tcdm_pkg::amo_op_e                in_amo_i,
  input  wire logic                             in_write_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0]   in_addr_i,
  input  wire logic [tcdm_pkg::CoreIdWidth-1:0] in_core_id_i,
  input  wire logic                             amo_busy_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0]   amo_wb_addr_i,
  output logic                                  sc_pass_o,
  output logic                                  sc_resp_o,
  output logic                                  sc_fail_o
);

  logic                             resv_valid_q;
  logic [tcdm_pkg::AddrWidth-1:0]   resv_addr_q;
  logic [tcdm_pkg::CoreIdWidth-1:0] resv_id_q;

  logic is_lr;
  logic is_sc;
  logic set_resv;
  logic store_hit;
  logic wb_hit;

  assign is_lr    = req_accept_i && (in_amo_i == tcdm_pkg::AmoLr);
  assign is_sc    = req_accept_i && (in_amo_i == tcdm_pkg::AmoSc);
  assign set_resv = is_lr;

  // sc passes only for the holder of a live reservation on that word
  assign sc_pass_o = is_sc && resv_valid_q &&
                     (resv_addr_q == in_addr_i) && (resv_id_q == in_core_id_i);

  // any core writing the reserved word breaks the reservation
  assign store_hit = req_accept_i && in_write_i && (in_amo_i == tcdm_pkg::AmoNone) &&
                     (in_addr_i == resv_addr_q);
  assign wb_hit    = amo_busy_i && (amo_wb_addr_i == resv_addr_q);

  // ----------------------------------------------------------
  // reservation state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
    end else if (set_resv) begin
      resv_valid_q <= 1'b1;
    end else if (sc_pass_o || store_hit || wb_hit) begin
      resv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (set_resv) begin
      resv_addr_q <= in_addr_i;
      resv_id_q   <= in_core_id_i;
    end
  end

  // sc outcome, lines up with the response push one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sc_resp_o <= 1'b0;
      sc_fail_o <= 1'b0;
    end else begin
      sc_resp_o <= is_sc;
      sc_fail_o <= is_sc && !sc_pass_o;
    end
  end

endmodule

`default_nettype wire

/* amo_unit.sv */
// ----------------------------------------------------------
// atomic read-modify-write sequencer
// captures the request, writes the result back one cycle later
// ----------------------------------------------------------
`default_nettype none

module amo_unit (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           req_accept_i,
  input  wire tcdm_pkg::amo_op_e              in_amo_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0] in_addr_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] in_wdata_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] mem_rdata_i,
  output logic                                amo_busy_o,
  output logic      [tcdm_pkg::AddrWidth-1:0] amo_wb_addr_o,
  output logic      [tcdm_pkg::DataWidth-1:0] amo_wb_data_o
);

  tcdm_pkg::amo_state_e           state_q;
  tcdm_pkg::amo_state_e           state_d;
  tcdm_pkg::amo_op_e              op_q;
  logic [tcdm_pkg::AddrWidth-1:0] addr_q;
  logic [tcdm_pkg::DataWidth-1:0] operand_q;
  logic                           load_amo;

  // lr and sc are handled by the reservation logic, not here
  assign load_amo = req_accept_i &&
                    (in_amo_i inside {[tcdm_pkg::AmoSwap : tcdm_pkg::AmoMinu]});

  // ----------------------------------------------------------
  // fsm
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      tcdm_pkg::AmoIdle:  if (load_amo) state_d = tcdm_pkg::AmoWrite;
      tcdm_pkg::AmoWrite: state_d = tcdm_pkg::AmoIdle;
      default:            state_d = tcdm_pkg::AmoIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tcdm_pkg::AmoIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // opcode, address and operand of the pending atomic
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      op_q      <= in_amo_i;
      addr_q    <= in_addr_i;
      operand_q <= in_wdata_i;
    end
  end

  // old word arrives from the sram in the write cycle
  amo_alu i_amo_alu (
    .op_i      (op_q),
    .mem_i     (mem_rdata_i),
    .operand_i (operand_q),
    .result_o  (amo_wb_data_o)
  );

  assign amo_busy_o    = (state_q == tcdm_pkg::AmoWrite);
  assign amo_wb_addr_o = addr_q;

  // a second atomic during the write-back would need another write cycle
  a_single_wb : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == tcdm_pkg::AmoWrite) |-> !load_amo
  );

endmodule

`default_nettype wire

/* amo_alu.sv */
// ----------------------------------------------------------
// atomic write-back value from old word and operand
// ----------------------------------------------------------
`default_nettype none

module amo_alu (
  input  wire tcdm_pkg::amo_op_e              op_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] mem_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0] operand_i,
  output logic      [tcdm_pkg::DataWidth-1:0] result_o
);

  localparam int unsigned Msb = tcdm_pkg::DataWidth - 1;

  // one extra bit so that signed and unsigned compares share the adder
  logic [tcdm_pkg::DataWidth:0] adder_a;
  logic [tcdm_pkg::DataWidth:0] adder_b;
  logic [tcdm_pkg::DataWidth:0] adder_sum;
  logic                         mem_lt_op;

  // operand shaping, default is a signed subtract
  always_comb begin
    adder_a = {mem_i[Msb], mem_i};
    adder_b = -{operand_i[Msb], operand_i};
    case (op_i)
      tcdm_pkg::AmoAdd: begin
        adder_b = {1'b0, operand_i};
      end
      tcdm_pkg::AmoMaxu, tcdm_pkg::AmoMinu: begin
        adder_a = {1'b0, mem_i};
        adder_b = -{1'b0, operand_i};
      end
      default: begin
      end
    endcase
  end

  assign adder_sum = adder_a + adder_b;
  // negative difference means the old word is the smaller one
  assign mem_lt_op = adder_sum[tcdm_pkg::DataWidth];

  always_comb begin
    case (op_i)
      tcdm_pkg::AmoSwap: result_o = operand_i;
      tcdm_pkg::AmoAdd:  result_o = adder_sum[Msb:0];
      tcdm_pkg::AmoAnd:  result_o = mem_i & operand_i;
      tcdm_pkg::AmoOr:   result_o = mem_i | operand_i;
      tcdm_pkg::AmoXor:  result_o = mem_i ^ operand_i;
      tcdm_pkg::AmoMax, tcdm_pkg::AmoMaxu: begin
        result_o = mem_lt_op ? operand_i : mem_i;
      end
      tcdm_pkg::AmoMin, tcdm_pkg::AmoMinu: begin
        result_o = mem_lt_op ? mem_i : operand_i;
      end
      default:           result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* tcdm_sram.sv */
// ----------------------------------------------------------
// single-port bank memory, byte-masked write, registered read
// ----------------------------------------------------------
`default_nettype none

module tcdm_sram (
  input  wire logic                               clk_i,
  input  wire logic                               mem_req_i,
  input  wire logic                               mem_we_i,
  input  wire logic [tcdm_pkg::AddrWidth-1:0]     mem_addr_i,
  input  wire logic [tcdm_pkg::DataWidth-1:0]     mem_wdata_i,
  input  wire logic [tcdm_pkg::BeWidth-1:0]       mem_be_i,
  output logic      [tcdm_pkg::DataWidth-1:0]     mem_rdata_o
);

  logic [tcdm_pkg::DataWidth-1:0] mem_q [tcdm_pkg::NumWords];

  // write path, one byte lane per enable
  always_ff @(posedge clk_i) begin
    if (mem_req_i && mem_we_i) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (mem_be_i[b]) begin
          mem_q[mem_addr_i][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read data shows up the cycle after the request and then holds
  always_ff @(posedge clk_i) begin
    if (mem_req_i && !mem_we_i) begin
      mem_rdata_o <= mem_q[mem_addr_i];
    end
  end

endmodule

`default_nettype wire

/* tcdm_pkg.sv */
// ----------------------------------------------------------
// shared widths, atomic opcode encoding and atomic unit state
// for the tcdm bank
// ----------------------------------------------------------
`default_nettype none

package tcdm_pkg;

  // data path
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  // bank geometry, word addressed
  localparam int unsigned AddrWidth   = 8;
  localparam int unsigned NumWords    = 256;
  // requester tag
  localparam int unsigned CoreIdWidth = 4;

  // atomic opcodes, encoding shared with the core side
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_e;

  // atomic unit owns the sram port in AmoWrite
  typedef enum logic {
    AmoIdle  = 1'b0,
    AmoWrite = 1'b1
  } amo_state_e;

endpackage

`default_nettype wire
